//--- vlog.f
hw/esfaPkg.sv
hw/vectorRom.sv
hw/vectorSequencer.sv
hw/vectorFifo.sv
hw/esfaStore.sv
hw/resultChecker.sv
hw/esfaBench.sv
test/clockGen.sv
test/esfaBenchTb.sv

//--- run.sh
#!/bin/sh
# Build and run the ESFA bench simulation with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module esfaBenchTb -o esfaSim \
  && ./obj_dir/esfaSim > sim.log 2>&1 \
  || echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "TESTBENCH PASSED" sim.log 2>/dev/null \
  && echo "Simulation passed" && exit 0 \
  || echo "Simulation failed" && exit 1

//--- test/esfaBenchTb.sv
`timescale 1ns/10ps

module esfaBenchTb
  import esfaPkg::*;
();

  // Six runs in all since the rerun test makes two
  localparam int RunCount = 6;
  localparam int CyclesPerRun = 300;
  localparam int CycleLimit = RunCount * CyclesPerRun;

  logic                    clk;
  logic                    reset;
  logic                    doRun;
  logic                    loadEnable;
  logic [RomAddrWidth-1:0] loadAddress;
  logic [VectorWidth-1:0]  loadData;
  logic                    isRunning;
  logic                    wasSuccessful;

  logic [VectorWidth-1:0] progWords [$];
  logic [DataWidth-1:0]   model [HandleCount][EntryCount];
  int                     errorCount = 0;
  int                     cycleCount = 0;
  integer                 seed;

  clockGen clockSource (.clk(clk));

  esfaBench dut (
    .clk           (clk),
    .reset         (reset),
    .doRun         (doRun),
    .loadEnable    (loadEnable),
    .loadAddress   (loadAddress),
    .loadData      (loadData),
    .isRunning     (isRunning),
    .wasSuccessful (wasSuccessful)
  );

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Vector building and the store model
  ////////////////////////////////////////////////////////////

  // Fields from bit 0 up are opcode, handle, index, value, bool and expected value
  function automatic logic [VectorWidth-1:0] makeVector(input esfaOp op,
      input logic [HandleWidth-1:0] handle, input logic [IndexWidth-1:0] index,
      input logic [DataWidth-1:0] value, input logic expBool,
      input logic [DataWidth-1:0] expValue);
    return {7'b0, expValue, expBool, value, index, handle, op};
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
      errorCount++;
    end
  endtask

  // Store is cleared at run start, so the model starts empty too
  task automatic newProgram();
    progWords.delete();
    for (int h = 0; h < HandleCount; h++) begin
      for (int e = 0; e < EntryCount; e++) begin
        model[h][e] = '0;
      end
    end
  endtask

  task automatic writeEntry(input logic [HandleWidth-1:0] h,
      input logic [IndexWidth-1:0] i, input logic [DataWidth-1:0] v);
    progWords.push_back(makeVector(opWrite, h, i, v, 1'b0, '0));
    model[h][i] = v;
  endtask

  task automatic clearHandle(input logic [HandleWidth-1:0] h);
    progWords.push_back(makeVector(opClear, h, '0, '0, 1'b0, '0));
    for (int e = 0; e < EntryCount; e++) begin
      model[h][e] = '0;
    end
  endtask

  task automatic readExpecting(input logic [HandleWidth-1:0] h,
      input logic [IndexWidth-1:0] i, input logic b, input logic [DataWidth-1:0] v);
    progWords.push_back(makeVector(opRead, h, i, '0, b, v));
  endtask

  task automatic readEntry(input logic [HandleWidth-1:0] h, input logic [IndexWidth-1:0] i);
    readExpecting(h, i, model[h][i] != '0, model[h][i]);
  endtask

  // Lowest matching index wins and zero means no match
  task automatic containsQuery(input logic [HandleWidth-1:0] h,
      input logic [DataWidth-1:0] v);
    logic                  hit;
    logic [IndexWidth-1:0] first;
    hit = 1'b0;
    first = '0;
    for (int e = 0; e < EntryCount; e++) begin
      if (!hit && model[h][e] == v) begin
        hit = 1'b1;
        first = IndexWidth'(e);
      end
    end
    progWords.push_back(makeVector(opContains, h, '0, v, hit, DataWidth'(first)));
  endtask

  task automatic endProgram();
    progWords.push_back(makeVector(opEnd, '0, '0, '0, 1'b0, '0));
  endtask

  ////////////////////////////////////////////////////////////
  // Loading and running
  ////////////////////////////////////////////////////////////

  task automatic loadProgram();
    if (progWords.size() > RomDepth) begin
      $display("Program of %0d words does not fit the program memory", progWords.size());
      errorCount++;
    end
    for (int a = 0; a < progWords.size() && a < RomDepth; a++) begin
      loadEnable = 1'b1;
      loadAddress = RomAddrWidth'(a);
      loadData = progWords[a];
      @(negedge clk);
    end
    loadEnable = 1'b0;
  endtask

  task automatic runProgram(input logic expectPass);
    loadProgram();
    doRun = 1'b1;
    @(negedge clk);
    doRun = 1'b0;
    checkValue("isRunning", 32'(1'b1), 32'(isRunning));
    checkValue("wasSuccessful", 32'(1'b1), 32'(wasSuccessful));
    while (isRunning) begin
      @(negedge clk);
    end
    checkValue("wasSuccessful", 32'(expectPass), 32'(wasSuccessful));
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic resetState();
    checkValue("isRunning", 32'(1'b0), 32'(isRunning));
    checkValue("wasSuccessful", 32'(1'b1), 32'(wasSuccessful));
  endtask

  // 29 words is well past the queue depth
  task automatic writeReadAllHandles();
    newProgram();
    for (int h = 0; h < HandleCount; h++) begin
      for (int i = 0; i < 3; i++) begin
        writeEntry(HandleWidth'(h), IndexWidth'(i), DataWidth'(h * 16 + i * 3 + 1));
      end
      for (int i = 0; i < 4; i++) begin
        readEntry(HandleWidth'(h), IndexWidth'(i));
      end
    end
    endProgram();
    runProgram(1'b1);
  endtask

  task automatic wrongExpectedValue();
    newProgram();
    writeEntry(2'd1, 3'd2, 8'h5a);
    readEntry(2'd1, 3'd2);
    readExpecting(2'd1, 3'd2, 1'b1, 8'h5b);
    readEntry(2'd1, 3'd3);
    endProgram();
    runProgram(1'b0);
  endtask

  task automatic wrongExpectedBool();
    newProgram();
    writeEntry(2'd0, 3'd7, 8'h33);
    readExpecting(2'd0, 3'd7, 1'b0, 8'h33);
    readEntry(2'd0, 3'd7);
    endProgram();
    runProgram(1'b0);
  endtask

  task automatic containsAndClear();
    logic [31:0] r;
    newProgram();
    // Narrow value range so duplicates show up and the first match matters
    for (int i = 0; i < EntryCount; i++) begin
      r = $random(seed);
      writeEntry(2'd2, IndexWidth'(i), {4'h1, r[3:0]});
    end
    for (int i = 0; i < EntryCount; i++) begin
      containsQuery(2'd2, model[2][i]);
    end
    for (int k = 0; k < 4; k++) begin
      r = $random(seed);
      containsQuery(2'd2, {4'h1, r[3:0]});
    end
    containsQuery(2'd1, 8'h00);
    clearHandle(2'd2);
    readExpecting(2'd2, 3'd0, 1'b0, 8'h00);
    containsQuery(2'd2, 8'h10);
    endProgram();
    runProgram(1'b1);
  endtask

  task automatic rerunAfterFailure();
    newProgram();
    writeEntry(2'd3, 3'd5, 8'h77);
    readExpecting(2'd3, 3'd5, 1'b1, 8'h78);
    endProgram();
    runProgram(1'b0);
    // Entry written by the failed run must be gone
    newProgram();
    readExpecting(2'd3, 3'd5, 1'b0, 8'h00);
    writeEntry(2'd3, 3'd5, 8'h21);
    readEntry(2'd3, 3'd5);
    endProgram();
    runProgram(1'b1);
  endtask

  initial begin
    seed = 24;
    reset = 1'b0;
    doRun = 1'b0;
    loadEnable = 1'b0;
    loadAddress = '0;
    loadData = '0;
    repeat (3) @(negedge clk);
    reset = 1'b1;

    resetState();
    writeReadAllHandles();
    wrongExpectedValue();
    wrongExpectedBool();
    containsAndClear();
    rerunAfterFailure();

    $display("Checks done, %0d errors after %0d cycles", errorCount, cycleCount);
    if (errorCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- test/clockGen.sv
`timescale 1ns/10ps

module clockGen (
  output logic clk
);

  // 4 ns period
  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

endmodule

//--- hw/esfaBench.sv
`timescale 1ns/10ps

module esfaBench
  import esfaPkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    doRun,
  input  logic                    loadEnable,
  input  logic [RomAddrWidth-1:0] loadAddress,
  input  logic [VectorWidth-1:0]  loadData,
  output logic                    isRunning,
  output logic                    wasSuccessful
);

  logic                    romRead;
  logic [RomAddrWidth-1:0] romAddr;
  logic [VectorWidth-1:0]  romData;
  logic                    pushValid;
  logic [VectorWidth-1:0]  pushData;
  logic                    popValid;
  logic [VectorWidth-1:0]  popData;
  logic                    pop;
  logic                    creditReturn;
  logic                    runStart;
  logic                    runHalt;

  vectorRom rom (
    .clk         (clk),
    .romRead     (romRead),
    .romAddr     (romAddr),
    .romData     (romData),
    .loadEnable  (loadEnable),
    .loadAddress (loadAddress),
    .loadData    (loadData)
  );

  vectorSequencer sequencer (
    .clk          (clk),
    .reset        (reset),
    .runStart     (runStart),
    .runHalt      (runHalt),
    .romRead      (romRead),
    .romAddr      (romAddr),
    .romData      (romData),
    .pushValid    (pushValid),
    .pushData     (pushData),
    .creditReturn (creditReturn)
  );

  // Halt of a run empties the queue
  vectorFifo fifo (
    .clk          (clk),
    .reset        (reset),
    .flush        (runHalt),
    .pushValid    (pushValid),
    .pushData     (pushData),
    .popValid     (popValid),
    .popData      (popData),
    .pop          (pop),
    .creditReturn (creditReturn)
  );

  resultChecker checkerUnit (
    .clk           (clk),
    .reset         (reset),
    .doRun         (doRun),
    .popValid      (popValid),
    .popData       (popData),
    .pop           (pop),
    .runStart      (runStart),
    .runHalt       (runHalt),
    .isRunning     (isRunning),
    .wasSuccessful (wasSuccessful)
  );

endmodule

//--- hw/resultChecker.sv
`timescale 1ns/10ps

module resultChecker
  import esfaPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   doRun,
  input  logic                   popValid,
  input  logic [VectorWidth-1:0] popData,
  output logic                   pop,
  output logic                   runStart,
  output logic                   runHalt,
  output logic                   isRunning,
  output logic                   wasSuccessful
);

  typedef enum logic [1:0] {stIdle, stFetch, stCompare} checkerState;

  checkerState            state;
  esfaOp                  headOp;
  logic                   storeEnable;
  logic                   resultBool;
  logic [DataWidth-1:0]   resultValue;
  logic                   queryPending;
  logic                   expBool;
  logic [DataWidth-1:0]   expValue;
  logic                   mismatch;

  assign headOp = esfaOp'(popData[OpcodeLsb +: OpcodeWidth]);

  // Fetch and compare alternate, so at most one pop every two cycles
  assign pop = (state == stFetch) && popValid;
  assign storeEnable = pop && (headOp != opEnd);

  assign mismatch = queryPending &&
                    ((resultBool != expBool) || (resultValue != expValue));

  esfaStore store (
    .clk         (clk),
    .reset       (reset),
    .storeClear  (runStart),
    .storeEnable (storeEnable),
    .storeOp     (headOp),
    .storeHandle (popData[HandleLsb +: HandleWidth]),
    .storeIndex  (popData[IndexLsb +: IndexWidth]),
    .storeValue  (popData[ValueLsb +: DataWidth]),
    .resultBool  (resultBool),
    .resultValue (resultValue)
  );

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= stIdle;
      isRunning <= 1'b0;
      wasSuccessful <= 1'b1;
      runStart <= 1'b0;
      runHalt <= 1'b0;
      queryPending <= 1'b0;
    end else begin
      runStart <= 1'b0;
      runHalt <= 1'b0;
      case (state)
        stIdle: begin
          if (doRun) begin
            state <= stFetch;
            isRunning <= 1'b1;
            wasSuccessful <= 1'b1;
            runStart <= 1'b1;
          end
        end
        stFetch: begin
          if (pop) begin
            queryPending <= (headOp == opRead) || (headOp == opContains);
            if (headOp == opEnd) begin
              state <= stIdle;
              isRunning <= 1'b0;
              runHalt <= 1'b1;
            end else begin
              state <= stCompare;
            end
          end
        end
        stCompare: begin
          queryPending <= 1'b0;
          if (mismatch) begin
            state <= stIdle;
            isRunning <= 1'b0;
            wasSuccessful <= 1'b0;
            runHalt <= 1'b1;
          end else begin
            state <= stFetch;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Expected answer rides along with the popped query
  always_ff @(posedge clk) begin
    if (pop) begin
      expBool <= popData[ExpBoolBit];
      expValue <= popData[ExpValueLsb +: DataWidth];
    end
  end

  // Halt flushes the queue so nothing is left over for the next run
  haltEmptiesQueue: assert property (@(posedge clk) disable iff (!reset)
    runHalt |=> !popValid)
    else $error("vector queue still holds data after run halt");

endmodule

//--- hw/esfaStore.sv
`timescale 1ns/10ps

module esfaStore
  import esfaPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   storeClear,
  input  logic                   storeEnable,
  input  esfaOp                  storeOp,
  input  logic [HandleWidth-1:0] storeHandle,
  input  logic [IndexWidth-1:0]  storeIndex,
  input  logic [DataWidth-1:0]   storeValue,
  output logic                   resultBool,
  output logic [DataWidth-1:0]   resultValue
);

  logic [DataWidth-1:0]  entries [HandleCount][EntryCount];
  logic [DataWidth-1:0]  selectedEntry;
  logic                  containsHit;
  logic [IndexWidth-1:0] containsIndex;

  assign selectedEntry = entries[storeHandle][storeIndex];

  // Scan from the top down so the lowest matching index wins
  always_comb begin
    containsHit = 1'b0;
    containsIndex = '0;
    for (int i = EntryCount - 1; i >= 0; i--) begin
      if (entries[storeHandle][i] == storeValue) begin
        containsHit = 1'b1;
        containsIndex = IndexWidth'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Mutating operations
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (storeClear) begin
      for (int h = 0; h < HandleCount; h++) begin
        for (int e = 0; e < EntryCount; e++) begin
          entries[h][e] <= '0;
        end
      end
    end else if (storeEnable) begin
      case (storeOp)
        opWrite: entries[storeHandle][storeIndex] <= storeValue;
        opClear: begin
          for (int e = 0; e < EntryCount; e++) begin
            entries[storeHandle][e] <= '0;
          end
        end
        default: ;
      endcase
    end
  end

  // Query answers, valid the cycle after the request
  always_ff @(posedge clk) begin
    if (!reset) begin
      resultBool <= 1'b0;
      resultValue <= '0;
    end else if (storeEnable) begin
      case (storeOp)
        opRead: begin
          resultBool <= (selectedEntry != '0);
          resultValue <= selectedEntry;
        end
        opContains: begin
          resultBool <= containsHit;
          resultValue <= DataWidth'(containsIndex);
        end
        default: ;
      endcase
    end
  end

endmodule

//--- hw/vectorFifo.sv
`timescale 1ns/10ps

module vectorFifo
  import esfaPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   flush,
  input  logic                   pushValid,
  input  logic [VectorWidth-1:0] pushData,
  output logic                   popValid,
  output logic [VectorWidth-1:0] popData,
  input  logic                   pop,
  output logic                   creditReturn
);

  logic [VectorWidth-1:0]   slots [FifoDepth];
  logic [FifoAddrWidth-1:0] wrPtr;
  logic [FifoAddrWidth-1:0] rdPtr;
  logic [CreditWidth-1:0]   count;
  logic                     doPush;
  logic                     doPop;

  assign popValid = (count != '0);
  assign popData = slots[rdPtr];

  assign doPush = pushValid && !flush;
  assign doPop = pop && popValid && !flush;

  // One credit back to the sequencer per word taken
  assign creditReturn = doPop;

  always_ff @(posedge clk) begin
    if (!reset || flush) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      count <= count + CreditWidth'(doPush) - CreditWidth'(doPop);
    end
  end

  always_ff @(posedge clk) begin
    if (doPush) begin
      slots[wrPtr] <= pushData;
    end
  end

  // Sequencer must never push without a slot reserved by a credit
  pushIntoFull: assert property (@(posedge clk) disable iff (!reset)
    doPush |-> count < CreditWidth'(FifoDepth))
    else $error("push into full vector queue, credit protocol broken");

endmodule

//--- hw/vectorSequencer.sv
`timescale 1ns/10ps

module vectorSequencer
  import esfaPkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    runStart,
  input  logic                    runHalt,
  output logic                    romRead,
  output logic [RomAddrWidth-1:0] romAddr,
  input  logic [VectorWidth-1:0]  romData,
  output logic                    pushValid,
  output logic [VectorWidth-1:0]  pushData,
  input  logic                    creditReturn
);

  logic                    running;
  logic                    inFlight;
  logic                    endSeen;
  logic                    endArriving;
  logic [RomAddrWidth-1:0] pc;
  logic [CreditWidth-1:0]  credits;

  // Word coming back from the ROM is the end marker
  assign endArriving = inFlight &&
                       (esfaOp'(romData[OpcodeLsb +: OpcodeWidth]) == opEnd);

  // A read spends a credit and its word lands in the queue next cycle
  assign romRead = running && !runHalt && !endSeen && !endArriving &&
                   (credits != '0);
  assign romAddr = pc;

  assign pushValid = inFlight;
  assign pushData = romData;

  ////////////////////////////////////////////////////////////
  // Program counter, credits and read tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!reset) begin
      running <= 1'b0;
      inFlight <= 1'b0;
      endSeen <= 1'b0;
      pc <= '0;
      credits <= CreditWidth'(FifoDepth);
    end else if (runHalt) begin
      // Queue gets flushed too, so every credit comes home
      running <= 1'b0;
      inFlight <= 1'b0;
      endSeen <= 1'b0;
      credits <= CreditWidth'(FifoDepth);
    end else begin
      if (runStart) begin
        running <= 1'b1;
        endSeen <= 1'b0;
        pc <= '0;
      end else if (romRead) begin
        pc <= pc + 1'b1;
      end
      if (endArriving) begin
        endSeen <= 1'b1;
      end
      inFlight <= romRead;
      credits <= credits - CreditWidth'(romRead) + CreditWidth'(creditReturn);
    end
  end

  creditBound: assert property (@(posedge clk) disable iff (!reset)
    credits <= CreditWidth'(FifoDepth))
    else $error("credit count above queue depth");

endmodule

//--- hw/vectorRom.sv
`timescale 1ns/10ps

module vectorRom
  import esfaPkg::*;
(
  input  logic                    clk,
  input  logic                    romRead,
  input  logic [RomAddrWidth-1:0] romAddr,
  output logic [VectorWidth-1:0]  romData,
  input  logic                    loadEnable,
  input  logic [RomAddrWidth-1:0] loadAddress,
  input  logic [VectorWidth-1:0]  loadData
);

  logic [VectorWidth-1:0] words [RomDepth];

  // Program load from outside, only while idle
  always_ff @(posedge clk) begin
    if (loadEnable) begin
      words[loadAddress] <= loadData;
    end
  end

  // Registered read, word shows up the cycle after romRead
  always_ff @(posedge clk) begin
    if (romRead) begin
      romData <= words[romAddr];
    end
  end

  // Loading is only legal while no run is fetching
  loadDuringRead: assert property (@(posedge clk) !(loadEnable && romRead))
    else $error("program load collided with a sequencer read");

endmodule

//--- hw/esfaPkg.sv
package esfaPkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int VectorWidth = 32;

  localparam int RomDepth = 64;
  localparam int RomAddrWidth = 6;

  // Queue depth doubles as the starting credit count
  localparam int FifoDepth = 4;
  localparam int FifoAddrWidth = 2;
  localparam int CreditWidth = 3;

  localparam int HandleCount = 4;
  localparam int HandleWidth = 2;
  localparam int EntryCount = 8;
  localparam int IndexWidth = 3;
  localparam int DataWidth = 8;

  // Write and clear mutate, read and contains are queries
  typedef enum logic [2:0] {
    opWrite    = 3'd0,
    opClear    = 3'd1,
    opRead     = 3'd2,
    opContains = 3'd3,
    opEnd      = 3'd4
  } esfaOp;

  ////////////////////////////////////////////////////////////
  // Vector word layout, low bits first
  ////////////////////////////////////////////////////////////

  localparam int OpcodeWidth = 3;
  localparam int OpcodeLsb = 0;
  localparam int HandleLsb = 3;
  localparam int IndexLsb = 5;
  localparam int ValueLsb = 8;
  localparam int ExpBoolBit = 16;
  localparam int ExpValueLsb = 17;

endpackage
